//--- Makefile
# Verilator build and run for the irq_core testbench

VERILATOR ?= verilator
TOP       ?= irq_core_tb
FILELIST  ?= irq_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/branch_exec.sv
module branch_exec (
    input  logic              id_is_branch,
    input  core_pkg::funct3_t id_funct3,
    input  core_pkg::pc_t     id_br_target,
    input  logic              br_cond,
    output logic              ex_redirect,
    output core_pkg::pc_t     ex_target
);

    logic taken;

    // ####################
    // branch condition
    // ####################

    // br_cond stands in for the compare result of rs1 and rs2
    always_comb begin
        case (id_funct3)
            core_pkg::F3_BEQ: taken = br_cond;
            core_pkg::F3_BNE: taken = !br_cond;
            default:          taken = 1'b0;  // never marked as branch in decode
        endcase
    end

    // redirect only for a live branch in execute
    assign ex_redirect = id_is_branch && taken;

    // target was summed from registered pc and offset
    assign ex_target = id_br_target;

endmodule

//--- design/core_pkg.sv
package core_pkg;

    // ####################
    // widths
    // ####################

    typedef logic [11:0] pc_t;      // instruction byte address
    typedef logic [31:0] instr_t;   // raw instruction word
    typedef logic [6:0]  opcode_t;  // instr[6:0]
    typedef logic [2:0]  funct3_t;  // instr[14:12]

    // ####################
    // encodings
    // ####################

    localparam opcode_t OP_JAL    = 7'h6f;
    localparam opcode_t OP_BRANCH = 7'h63;
    localparam opcode_t OP_SYSTEM = 7'h73;  // only URET is expected here

    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    // addi x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // interrupt controller sequencing
    typedef enum logic [1:0] {
        idle,        // normal program flow
        enter_wait,  // draining before the jump to the service routine
        in_isr,      // service routine running
        ret_wait     // URET seen, waiting out the return
    } isr_state_t;

endpackage

//--- design/instr_decode.sv
module instr_decode (
    input  logic              clk,
    input  logic              nrst,
    input  logic              fetch_en,
    input  logic              ex_redirect,
    input  core_pkg::pc_t     if_pc,
    input  core_pkg::instr_t  if_instr,
    output core_pkg::opcode_t if_opcode,
    output logic              id_sel_pc,
    output core_pkg::pc_t     id_target,
    output logic              id_is_branch,
    output core_pkg::funct3_t id_funct3,
    output core_pkg::pc_t     id_br_target
);

    core_pkg::funct3_t if_funct3;
    core_pkg::pc_t     j_off;
    core_pkg::pc_t     b_off;
    logic              if_is_branch;
    core_pkg::pc_t     id_pc;
    core_pkg::pc_t     id_br_off;

    // ####################
    // field extraction
    // ####################

    assign if_opcode = if_instr[6:0];
    assign if_funct3 = if_instr[14:12];

    // immediates cut down to the 12-bit address space
    assign j_off = {if_instr[20], if_instr[30:21], 1'b0};
    assign b_off = {if_instr[7], if_instr[30:25], if_instr[11:8], 1'b0};

    assign id_sel_pc = (if_opcode == core_pkg::OP_JAL);  // JAL resolves right here
    assign id_target = if_pc + j_off;

    assign if_is_branch = (if_opcode == core_pkg::OP_BRANCH) &&
                          ((if_funct3 == core_pkg::F3_BEQ) || (if_funct3 == core_pkg::F3_BNE));

    // ####################
    // decode/execute register
    // ####################

    always_ff @(posedge clk) begin
        if (!nrst)
            id_is_branch <= 1'b0;
        else if (ex_redirect)
            id_is_branch <= 1'b0;  // squash the younger slot
        else if (fetch_en)
            id_is_branch <= if_is_branch;
    end

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            id_pc     <= if_pc;
            id_br_off <= b_off;
            id_funct3 <= if_funct3;
        end
    end

    assign id_br_target = id_pc + id_br_off;

endmodule

//--- design/interrupt_controller.sv
module interrupt_controller #(
    parameter logic [2:0] STALL_CYCLES = 3'd3
) (
    input  logic              clk,
    input  logic              nrst,
    input  core_pkg::pc_t     pc,
    input  core_pkg::opcode_t if_opcode,
    input  logic              irq_n,
    input  logic              ex_redirect,
    input  logic              id_sel_pc,
    input  logic              fetch_en,
    output logic              isr_stall,
    output logic              sel_isr,
    output logic              ret_isr,
    output logic              isr_active,
    output core_pkg::pc_t     save_pc
);

    // fetch-enabled cycles from URET to the end of the return
    localparam logic [2:0] RET_CYCLES = 3'd2;

    core_pkg::isr_state_t state;
    logic [2:0]           stall_cnt;
    logic                 isr_en;         // armed for a new request
    logic                 uret_in_fetch;
    logic                 entry;
    logic                 cap_req;
    logic                 cap_q;

    assign uret_in_fetch = (if_opcode == core_pkg::OP_SYSTEM);
    assign isr_stall     = (stall_cnt != 3'd0) || uret_in_fetch;
    assign entry         = (state == core_pkg::idle) && !irq_n && isr_en;

    // pc settles one cycle after the event, so capture is delayed by one
    assign cap_req = entry ||
                     ((state == core_pkg::enter_wait) && isr_stall &&
                      (ex_redirect || id_sel_pc));

    // ####################
    // entry / return sequencing
    // ####################

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state      <= core_pkg::idle;
            stall_cnt  <= 3'd0;
            isr_en     <= 1'b1;
            sel_isr    <= 1'b0;
            ret_isr    <= 1'b0;
            isr_active <= 1'b0;
            cap_q      <= 1'b0;
        end else begin
            cap_q <= cap_req;
            case (state)
                core_pkg::idle: begin
                    if (entry) begin
                        state     <= core_pkg::enter_wait;
                        stall_cnt <= 3'd1;
                        isr_en    <= 1'b0;
                    end else if (irq_n && !isr_stall) begin
                        isr_en <= 1'b1;  // re-arm once the line is released
                    end
                end
                core_pkg::enter_wait: begin
                    if (stall_cnt == STALL_CYCLES) begin
                        stall_cnt <= 3'd0;
                        sel_isr   <= 1'b1;  // pc_unit jumps on the next edge
                    end else if (sel_isr) begin
                        state      <= core_pkg::in_isr;
                        isr_active <= 1'b1;
                    end else if (fetch_en) begin
                        stall_cnt <= stall_cnt + 3'd1;
                    end
                end
                core_pkg::in_isr: begin
                    // a URET being squashed by an older branch does not count
                    if (uret_in_fetch && !ex_redirect) begin
                        state     <= core_pkg::ret_wait;
                        ret_isr   <= 1'b1;
                        sel_isr   <= 1'b0;
                        stall_cnt <= 3'd1;
                    end
                end
                core_pkg::ret_wait: begin
                    if (stall_cnt == RET_CYCLES) begin
                        state      <= core_pkg::idle;
                        stall_cnt  <= 3'd0;
                        ret_isr    <= 1'b0;
                        isr_active <= 1'b0;
                    end else if (fetch_en) begin
                        stall_cnt <= stall_cnt + 3'd1;
                    end
                end
                default: state <= core_pkg::idle;
            endcase
        end
    end

    // the last resume address written during the drain wins
    always_ff @(posedge clk) begin
        if (cap_q)
            save_pc <= pc;
    end

endmodule

//--- design/irq_core.sv
module irq_core #(
    parameter core_pkg::pc_t ISR_ADDR     = 12'h100,
    parameter logic [2:0]    STALL_CYCLES = 3'd3
) (
    input  logic             clk,
    input  logic             nrst,
    input  logic             irq_n,
    input  logic             fetch_en,
    input  logic             br_cond,
    input  core_pkg::instr_t instr,
    output core_pkg::pc_t    pc,
    output logic             isr_active,
    output logic             isr_stall,
    output core_pkg::pc_t    save_pc
);

    // controller to pc_unit
    logic              sel_isr;
    logic              ret_isr;

    // fetch/decode stage
    core_pkg::pc_t     if_pc;
    core_pkg::instr_t  if_instr;
    core_pkg::opcode_t if_opcode;
    logic              id_sel_pc;
    core_pkg::pc_t     id_target;

    // decode/execute stage
    logic              id_is_branch;
    core_pkg::funct3_t id_funct3;
    core_pkg::pc_t     id_br_target;
    logic              ex_redirect;
    core_pkg::pc_t     ex_target;

    pc_unit #(
        .ISR_ADDR (ISR_ADDR)
    ) u_pc_unit (
        .clk, .nrst, .fetch_en, .isr_stall, .sel_isr, .ret_isr, .save_pc,
        .id_sel_pc, .id_target, .ex_redirect, .ex_target, .instr,
        .pc, .if_pc, .if_instr
    );

    instr_decode u_instr_decode (
        .clk, .nrst, .fetch_en, .ex_redirect, .if_pc, .if_instr,
        .if_opcode, .id_sel_pc, .id_target, .id_is_branch, .id_funct3, .id_br_target
    );

    branch_exec u_branch_exec (
        .id_is_branch, .id_funct3, .id_br_target, .br_cond,
        .ex_redirect, .ex_target
    );

    interrupt_controller #(
        .STALL_CYCLES (STALL_CYCLES)
    ) u_interrupt_controller (
        .clk, .nrst, .pc, .if_opcode, .irq_n, .ex_redirect, .id_sel_pc, .fetch_en,
        .isr_stall, .sel_isr, .ret_isr, .isr_active, .save_pc
    );

endmodule

//--- design/pc_unit.sv
module pc_unit #(
    parameter core_pkg::pc_t ISR_ADDR = 12'h100
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic              fetch_en,
    input  logic              isr_stall,
    input  logic              sel_isr,
    input  logic              ret_isr,
    input  core_pkg::pc_t     save_pc,
    input  logic              id_sel_pc,
    input  core_pkg::pc_t     id_target,
    input  logic              ex_redirect,
    input  core_pkg::pc_t     ex_target,
    input  core_pkg::instr_t  instr,
    output core_pkg::pc_t     pc,
    output core_pkg::pc_t     if_pc,
    output core_pkg::instr_t  if_instr
);

    logic          sel_isr_q;
    logic          ret_isr_q;
    logic          isr_jump;
    logic          ret_jump;
    logic          redirect;
    core_pkg::pc_t redirect_pc;

    // one jump per rising edge of the controller levels
    assign isr_jump = sel_isr && !sel_isr_q;
    assign ret_jump = ret_isr && !ret_isr_q;
    assign redirect = isr_jump || ret_jump || ex_redirect || id_sel_pc;

    always_comb begin
        if (isr_jump)         redirect_pc = ISR_ADDR;
        else if (ret_jump)    redirect_pc = save_pc;
        else if (ex_redirect) redirect_pc = ex_target;  // older stage wins over decode
        else                  redirect_pc = id_target;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            pc        <= '0;
            sel_isr_q <= 1'b0;
            ret_isr_q <= 1'b0;
        end else begin
            sel_isr_q <= sel_isr;
            ret_isr_q <= ret_isr;
            if (redirect)
                pc <= redirect_pc;  // taken even under stall
            else if (fetch_en && !isr_stall)
                pc <= pc + 12'd4;
        end
    end

    // fetch/decode register bubbles on redirect or while draining
    always_ff @(posedge clk) begin
        if (!nrst)
            if_instr <= core_pkg::NOP_INSTR;
        else if (redirect || (fetch_en && isr_stall))
            if_instr <= core_pkg::NOP_INSTR;
        else if (fetch_en)
            if_instr <= instr;
    end

    always_ff @(posedge clk) begin
        if (fetch_en)
            if_pc <= pc;
    end

endmodule

//--- irq_core.f
design/core_pkg.sv
design/pc_unit.sv
design/instr_decode.sv
design/branch_exec.sv
design/interrupt_controller.sv
design/irq_core.sv
sim/irq_core_tb.sv

//--- sim/irq_core_tb.sv
module irq_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam core_pkg::pc_t    ISR_ADDR       = 12'h100;
    localparam core_pkg::instr_t URET_WORD      = 32'h0020_0073;
    localparam int               TIMEOUT_CYCLES = 2000;  // tests take about 300 cycles

    logic             clk      = 1'b0;
    logic             nrst     = 1'b0;
    logic             irq_n    = 1'b1;
    logic             fetch_en = 1'b0;
    logic             br_cond  = 1'b0;
    core_pkg::instr_t instr;
    core_pkg::pc_t    pc;
    logic             isr_active;
    logic             isr_stall;
    core_pkg::pc_t    save_pc;

    core_pkg::instr_t mem [0:1023];
    logic [31:0]      lfsr       = 32'h4c87_3819;
    core_pkg::pc_t    exp_pc     = '0;   // reference model of sequential fetch
    logic             irq_level  = 1'b1;
    logic             cond_level = 1'b0;
    int               cycle_cnt  = 0;

    irq_core #(
        .ISR_ADDR     (ISR_ADDR),
        .STALL_CYCLES (3'd3)
    ) i_irq_core (
        .clk, .nrst, .irq_n, .fetch_en, .br_cond, .instr,
        .pc, .isr_active, .isr_stall, .save_pc
    );

    always #5 clk = ~clk;

    assign instr = mem[pc[11:2]];  // memory answers in the same cycle

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
            fail_run("the run did not finish within the cycle limit");
    end

    // ####################
    // helpers
    // ####################

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic rand_fetch();
        return |rand_bits(2);  // low one cycle in four
    endfunction

    function automatic core_pkg::instr_t jal_word(input core_pkg::pc_t off);
        return {off[11], off[10:1], off[11], {8{off[11]}}, 5'd0, 7'h6f};  // rd = x0
    endfunction

    function automatic core_pkg::instr_t branch_word(input logic [2:0] f3,
                                                     input core_pkg::pc_t off);
        return {off[11], off[10:5], 10'd0, f3, off[4:1], off[11], 7'h63};
    endfunction

    task automatic fill_mem();
        for (int i = 0; i < 1024; i++)
            mem[i] = {2'b00, i[9:0], 13'h0000, 7'h13};  // addi x0, x0, word index
    endtask

    task automatic place(input core_pkg::pc_t addr, input core_pkg::instr_t word);
        mem[addr[11:2]] = word;
    endtask

    task automatic reset_dut();
        @(posedge clk);
        nrst       <= 1'b0;
        fetch_en   <= 1'b0;
        irq_n      <= 1'b1;
        br_cond    <= 1'b0;
        irq_level  = 1'b1;
        cond_level = 1'b0;
        @(negedge clk);
        fill_mem();
        repeat (16) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        exp_pc = '0;
    endtask

    // one clock from falling edge to falling edge
    task automatic step(input logic fe);
        logic adv;
        adv = fetch_en && !isr_stall;
        @(posedge clk);
        fetch_en <= fe;
        irq_n    <= irq_level;
        br_cond  <= cond_level;
        @(negedge clk);
        if (adv)
            exp_pc = exp_pc + 12'd4;
    endtask

    task automatic wait_pc(input core_pkg::pc_t target, input int max_cycles);
        int n;
        n = 0;
        while (pc !== target) begin
            if (n == max_cycles)
                fail_run($sformatf("pc did not reach 0x%h within %0d cycles", target, max_cycles));
            step(1'b1);
            n++;
        end
    endtask

    // ####################
    // directed tests
    // ####################

    task automatic sequential_fetch();
        reset_dut();
        check("pc", 32'(pc), 32'h0);
        check("isr_stall", 32'(isr_stall), 32'h0);
        check("isr_active", 32'(isr_active), 32'h0);
        repeat (40) begin
            step(rand_fetch());
            check("pc", 32'(pc), 32'(exp_pc));
        end
    endtask

    task automatic jal_redirect();
        reset_dut();
        place(12'h020, jal_word(12'h0a0));
        place(12'h024, jal_word(12'h200));  // slot behind the jump
        wait_pc(12'h020, 12);
        wait_pc(12'h0c0, 3);
        exp_pc = 12'h0c0;
        repeat (6) begin
            step(1'b1);
            check("pc", 32'(pc), 32'(exp_pc));
        end
    endtask

    task automatic branch_resolve(input logic [2:0] f3, input logic cond);
        logic [31:0]   r;
        core_pkg::pc_t off;
        logic          taken;
        r     = rand_bits(6);
        off   = {4'h0, r[5:0], 2'b00} + 12'd16;  // clear of the two slots behind
        taken = (f3 == 3'b000) ? cond : !cond;   // BEQ on high, BNE on low
        reset_dut();
        place(12'h040, branch_word(f3, off));
        cond_level = cond;
        wait_pc(12'h040, 20);
        if (taken) begin
            wait_pc(12'h040 + off, 3);
            exp_pc = 12'h040 + off;
        end else begin
            exp_pc = 12'h040;
        end
        repeat (5) begin
            step(1'b1);
            check("pc", 32'(pc), 32'(exp_pc));
        end
    endtask

    task automatic enter_isr(output core_pkg::pc_t resume);
        int n;
        irq_level = 1'b0;
        n = 0;
        do begin
            if (n == 3)
                fail_run("isr_stall did not rise after irq_n went low");
            step(rand_fetch());
            check("pc", 32'(pc), 32'(exp_pc));
            n++;
        end while (isr_stall !== 1'b1);
        resume = exp_pc;  // next word that was never fetched
        n = 0;
        while (isr_active !== 1'b1) begin
            if (n == 20)
                fail_run("isr_active did not rise within 20 cycles of the request");
            check("pc", 32'(pc), 32'(resume));
            step(rand_fetch());
            n++;
        end
        check("pc", 32'(pc), 32'(ISR_ADDR));
        check("save_pc", 32'(save_pc), 32'(resume));
    endtask

    task automatic return_isr(input core_pkg::pc_t resume);
        int n;
        wait_pc(resume, 8);
        n = 0;
        while (isr_active !== 1'b0) begin
            if (n == 4)
                fail_run("isr_active did not clear after the return");
            step(1'b1);
            check("pc", 32'(pc), 32'(resume));
            n++;
        end
        exp_pc = resume;
    endtask

    task automatic interrupt_round_trip();
        core_pkg::pc_t resume;
        reset_dut();
        place(ISR_ADDR + 12'd8, URET_WORD);
        repeat (6) begin
            step(rand_fetch());
            check("pc", 32'(pc), 32'(exp_pc));
        end
        enter_isr(resume);
        return_isr(resume);
        // no new entry while irq_n stays low
        repeat (10) begin
            step(1'b1);
            check("isr_stall", 32'(isr_stall), 32'h0);
            check("isr_active", 32'(isr_active), 32'h0);
            check("pc", 32'(pc), 32'(exp_pc));
        end
        irq_level = 1'b1;
        repeat (3) begin
            step(1'b1);
            check("isr_stall", 32'(isr_stall), 32'h0);
            check("pc", 32'(pc), 32'(exp_pc));
        end
        enter_isr(resume);
        return_isr(resume);
    endtask

    initial begin
        fill_mem();
        sequential_fetch();
        jal_redirect();
        branch_resolve(3'b000, 1'b1);
        branch_resolve(3'b000, 1'b0);
        branch_resolve(3'b001, 1'b0);
        branch_resolve(3'b001, 1'b1);
        interrupt_round_trip();
        $display("All tests passed");
        $finish;
    end

endmodule
